// ==== build.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/imem_if.sv
logic/imem_backing.sv
logic/icache.sv
logic/if_stage.sv
logic/fetch_top.sv
dv/fetch_asserts.sv
dv/fetch_tb.sv

// ==== dv/fetch_tb.sv ====
`include "fetch_cfg.svh"

module fetch_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fetch_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int PROG_WORDS = 64;
	// every word missing with hazards around it, plus setup
	localparam int MAX_CYCLES = PROG_WORDS * (`IMEM_LATENCY + 2) * 4 + 500;

	logic        clk;
	logic        rst_n;
	logic        halt_n;
	logic        hazard_f;
	logic        dmem_stall;
	logic        branch_taken;
	logic [15:0] branch_target;
	logic        load_en;
	logic [15:0] load_addr;
	logic [15:0] load_data;
	logic [15:0] pc_plus2;
	logic [15:0] inst;
	logic        cache_hit;
	logic        imem_err;

	logic [31:0] lcg_state;
	logic        count_hits;
	int unsigned cycle_cnt = 0;
	int unsigned hit_cnt = 0;
	int unsigned check_errs = 0;

	fetch_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// hits are only counted while the loop runs a second time from the cache
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (count_hits && cache_hit) begin
			hit_cnt <= hit_cnt + 1;
		end
	end

	initial begin
		wait (cycle_cnt >= MAX_CYCLES);
		$display("Timeout after %0d cycles, the fetch sequence never finished", cycle_cnt);
		$display("Test failed");
		$finish;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// random program, the bubble encoding is never loaded
	task automatic load_program();
		inst_t word;
		for (int i = 0; i < PROG_WORDS; i++) begin
			lcg_state = lcg_next(lcg_state);
			word = lcg_state[31:16];
			if (word == NOP_INST) begin
				word = word ^ 16'h0001;
			end
			load_en   = 1'b1;
			load_addr = 16'(2 * i);
			load_data = word;
			next_cycle();
		end
		load_en = 1'b0;
	endtask

	task automatic run_until_pc(input logic [15:0] value);
		while (pc_plus2 != value) begin
			next_cycle();
		end
	endtask

	task automatic wait_word();
		while (inst == NOP_INST) begin
			next_cycle();
		end
	endtask

	task automatic branch_to(input logic [15:0] target);
		branch_taken  = 1'b1;
		branch_target = target;
		next_cycle();
		branch_taken = 1'b0;
	endtask

	initial begin
		rst_n         = 1'b0;
		halt_n        = 1'b0;
		hazard_f      = 1'b0;
		dmem_stall    = 1'b0;
		branch_taken  = 1'b0;
		branch_target = '0;
		load_en       = 1'b0;
		load_addr     = '0;
		load_data     = '0;
		count_hits    = 1'b0;
		lcg_state     = 32'hac5f6aca;

		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		load_program();
		next_cycle();
		halt_n = 1'b1;

		// straight-line first pass with back-pressure windows
		run_until_pc(16'd20);
		hazard_f = 1'b1;
		repeat (3) next_cycle();
		hazard_f = 1'b0;
		run_until_pc(16'd40);
		dmem_stall = 1'b1;
		repeat (4) next_cycle();
		dmem_stall = 1'b0;
		run_until_pc(16'd60);
		wait_word();
		hazard_f = 1'b1;
		repeat (2) next_cycle();
		hazard_f = 1'b0;
		halt_n = 1'b0;
		repeat (3) next_cycle();
		halt_n = 1'b1;

		// last word is still in flight when the branch comes
		run_until_pc(16'd128);
		repeat (2) next_cycle();
		branch_to(16'd0);

		// refill the first 16 words, then run them again from the cache
		run_until_pc(16'd32);
		wait_word();
		branch_to(16'd0);
		count_hits = 1'b1;
		run_until_pc(16'd32);
		wait_word();
		count_hits = 1'b0;
		branch_to(16'd0);

		// odd target, then back to an aligned one
		branch_to(16'd7);
		repeat (3) next_cycle();
		branch_to(16'd0);
		run_until_pc(16'd6);
		wait_word();
		repeat (4) next_cycle();

		if (hit_cnt == 0) begin
			check_errs++;
			$display("No cache hit was seen on the second pass over the loop");
		end

		$display("Run finished with %0d assertion failures and %0d other errors",
			DUT.u_asserts.fail_cnt, check_errs);
		if (DUT.u_asserts.fail_cnt == 0 && check_errs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== dv/fetch_asserts.sv ====
`include "fetch_cfg.svh"

module fetch_asserts (
	input logic        clk,
	input logic        rst_n,
	input logic        halt_n,
	input logic        hazard_f,
	input logic        dmem_stall,
	input logic        branch_taken,
	input logic [15:0] branch_target,
	input logic        load_en,
	input logic [15:0] load_addr,
	input logic [15:0] load_data,
	input logic [15:0] pc_plus2,
	input logic [15:0] inst,
	input logic        cache_hit,
	input logic        imem_err,
	input logic        mem_req
);
	timeunit 1ns;
	timeprecision 1ps;
	import fetch_pkg::*;

	localparam int MISS_NOPS = `IMEM_LATENCY + 1;

	logic [15:0] shadow [1 << `IMEM_ADDR_BITS];
	logic [15:0] fetch_pc;
	logic [15:0] exp_word;
	logic [15:0] pc_prev_q;
	logic [15:0] target_q;
	logic [15:0] exp_pc;
	logic        quiet;
	logic        seen_q;
	int unsigned fail_cnt = 0;

	// copy of every program load, same word aliasing as the backing memory
	always_ff @(posedge clk) begin
		if (load_en) begin
			shadow[load_addr[`IMEM_ADDR_BITS:1]] <= load_data;
		end
	end

	assign fetch_pc = pc_plus2 - 16'd2;
	assign exp_word = shadow[fetch_pc[`IMEM_ADDR_BITS:1]];

	always_ff @(posedge clk) begin
		pc_prev_q <= pc_plus2;
		target_q  <= branch_target;
	end

	assign exp_pc = target_q + 16'd2;

	// nothing can disturb the fetch in this cycle
	assign quiet = halt_n & ~hazard_f & ~branch_taken;

	// first word after reset not yet delivered
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seen_q <= 1'b0;
		end else if (inst != NOP_INST) begin
			seen_q <= 1'b1;
		end
	end

	word_matches_pc: assert property (@(posedge clk) disable iff (!rst_n)
		inst != NOP_INST |-> inst == exp_word)
	else begin
		fail_cnt++;
		$error("Mismatch at %0t: inst = %h, expected %h",
			$time, $sampled(inst), $sampled(exp_word));
	end

	pc_holds: assert property (@(posedge clk) disable iff (!rst_n)
		(!halt_n || ((hazard_f || dmem_stall) && !branch_taken)) |=> pc_plus2 == pc_prev_q)
	else begin
		fail_cnt++;
		$error("Mismatch at %0t: pc_plus2 = %h, expected %h",
			$time, $sampled(pc_plus2), $sampled(pc_prev_q));
	end

	hazard_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		hazard_f |-> inst == NOP_INST)
	else begin
		fail_cnt++;
		$error("Mismatch at %0t: inst = %h, expected %h", $time, $sampled(inst), NOP_INST);
	end

	branch_redirect: assert property (@(posedge clk) disable iff (!rst_n)
		branch_taken && halt_n |=> pc_plus2 == exp_pc)
	else begin
		fail_cnt++;
		$error("Mismatch at %0t: pc_plus2 = %h, expected %h",
			$time, $sampled(pc_plus2), $sampled(exp_pc));
	end

	branch_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		branch_taken |=> inst == NOP_INST)
	else begin
		fail_cnt++;
		$error("Mismatch at %0t: inst = %h, expected %h", $time, $sampled(inst), NOP_INST);
	end

	// request cycle plus the wait cycles are all bubbles
	miss_bubbles: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req |-> (inst == NOP_INST) [*MISS_NOPS])
	else begin
		fail_cnt++;
		$error("An instruction appeared at %0t before the cache miss was filled", $time);
	end

	miss_delivers: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_req && quiet && $past(inst) != NOP_INST) ##1 quiet [*MISS_NOPS]
			|-> inst != NOP_INST)
	else begin
		fail_cnt++;
		$error("The missed word did not arrive at %0t after the memory latency", $time);
	end

	hit_same_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		(cache_hit && !hazard_f && !branch_taken && $past(inst) != NOP_INST)
			|-> inst != NOP_INST)
	else begin
		fail_cnt++;
		$error("A cache hit at %0t did not deliver its word in the same cycle", $time);
	end

	odd_addr_err: assert property (@(posedge clk) disable iff (!rst_n)
		imem_err == (halt_n && pc_plus2[0]))
	else begin
		fail_cnt++;
		$error("Mismatch at %0t: imem_err = %b, expected %b",
			$time, $sampled(imem_err), $sampled(halt_n && pc_plus2[0]));
	end

	reset_bubble: assert property (@(posedge clk)
		!rst_n |-> inst == NOP_INST)
	else begin
		fail_cnt++;
		$error("Mismatch at %0t: inst = %h, expected %h", $time, $sampled(inst), NOP_INST);
	end

	reset_pc: assert property (@(posedge clk)
		!seen_q |-> pc_plus2 == 16'd2)
	else begin
		fail_cnt++;
		$error("Mismatch at %0t: pc_plus2 = %h, expected %h",
			$time, $sampled(pc_plus2), 16'd2);
	end

endmodule

bind fetch_top fetch_asserts u_asserts (.*);

// ==== logic/fetch_top.sv ====
module fetch_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        halt_n,
	input  logic        hazard_f,
	input  logic        dmem_stall,
	input  logic        branch_taken,
	input  logic [15:0] branch_target,
	input  logic        load_en,
	input  logic [15:0] load_addr,
	input  logic [15:0] load_data,
	output logic [15:0] pc_plus2,
	output logic [15:0] inst,
	output logic        cache_hit,
	output logic        imem_err
);

	logic        mem_req;
	logic [15:0] mem_addr;
	logic [15:0] mem_rdata;
	logic        mem_valid;

	imem_if imem_bus ();

	if_stage u_if_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.halt_n        (halt_n),
		.hazard_f      (hazard_f),
		.dmem_stall    (dmem_stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.imem          (imem_bus.fetch),
		.pc_plus2      (pc_plus2),
		.inst          (inst)
	);

	icache u_icache (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_addr (load_addr),
		.mem       (imem_bus.cache),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_rdata (mem_rdata),
		.mem_valid (mem_valid)
	);

	imem_backing u_imem_backing (
		.clk       (clk),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_rdata (mem_rdata),
		.mem_valid (mem_valid)
	);

	assign cache_hit = imem_bus.cache_hit;
	assign imem_err  = imem_bus.err;

endmodule

// ==== logic/if_stage.sv ====
module if_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   halt_n,
	input  logic                   hazard_f,
	input  logic                   dmem_stall,
	input  logic                   branch_taken,
	input  fetch_pkg::fetch_addr_u branch_target,
	imem_if.fetch                  imem,
	output logic [15:0]            pc_plus2,
	output fetch_pkg::inst_t       inst
);
	import fetch_pkg::*;

	fetch_addr_u pc_q;
	fetch_addr_u pc_d;
	logic        active_q;
	logic        branch_pend_q;
	logic        branch_pend_d;
	logic        is_branching;
	logic        mem_wait;
	logic        advance;

	// goes high on the first edge after reset is released
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active_q <= 1'b0;
		end else begin
			active_q <= 1'b1;
		end
	end

	assign imem.rd   = active_q & halt_n;
	assign imem.addr = pc_q;

	assign pc_plus2 = pc_q.flat + 16'd2;

	// memory not ready: miss in flight, word not done, or data side busy
	assign mem_wait = imem.stall | ~imem.done | dmem_stall;

	// a branch stays pending until the cache completes a fetch, so a word
	// that was in flight when the branch arrived is thrown away
	assign branch_pend_d = branch_taken | (branch_pend_q & ~imem.done);
	assign is_branching  = branch_taken | branch_pend_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			branch_pend_q <= 1'b0;
		end else begin
			branch_pend_q <= branch_pend_d;
		end
	end

	assign advance = ~is_branching & ~hazard_f & ~mem_wait;

	// next PC
	// sequential when nothing blocks, target on a taken branch,
	// otherwise hold
	always_comb begin
		if (advance) begin
			pc_d.flat = pc_plus2;
		end else if (branch_taken) begin
			pc_d = branch_target;
		end else begin
			pc_d = pc_q;
		end
	end

	// halt freezes the PC
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q.flat <= '0;
		end else if (halt_n) begin
			pc_q <= pc_d;
		end
	end

	// bubble while the word is not valid, under hazard, or around a branch
	assign inst = (~imem.done | hazard_f | is_branching) ? NOP_INST : imem.data;

endmodule

// ==== logic/icache.sv ====
`include "fetch_cfg.svh"

module icache (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   load_en,
	input  fetch_pkg::fetch_addr_u load_addr,
	imem_if.cache                  mem,
	output logic                   mem_req,
	output logic [15:0]            mem_addr,
	input  logic [15:0]            mem_rdata,
	input  logic                   mem_valid
);
	import fetch_pkg::*;

	localparam int LINES = 1 << `IC_INDEX_BITS;

	// miss FSM encodings
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WAIT = 2'd1;
	localparam logic [1:0] ST_FILL = 2'd2;

	logic [1:0]             state_q;
	logic [1:0]             state_d;
	logic [LINES-1:0]       valid_q;
	logic [IC_TAG_BITS-1:0] tag_arr [LINES];
	inst_t                  data_arr [LINES];
	fetch_addr_u            miss_addr_q;
	logic                   lookup_hit;
	logic                   aligned_rd;
	logic                   can_issue;
	logic                   fill_now;

	// odd addresses are flagged and never looked up
	assign aligned_rd = mem.rd & ~mem.addr.fld.offset;
	assign mem.err    = mem.rd & mem.addr.fld.offset;

	assign lookup_hit = valid_q[mem.addr.fld.index] &&
		(tag_arr[mem.addr.fld.index] == mem.addr.fld.tag);

	// no lookup answers while a fill is outstanding, a redirected
	// address is re-evaluated once the old fill lands
	assign can_issue = (state_q != ST_WAIT);

	assign mem_req  = aligned_rd & ~lookup_hit & can_issue;
	assign mem_addr = mem.addr.flat;

	assign mem.done  = aligned_rd & lookup_hit & can_issue;
	assign mem.stall = (state_q == ST_WAIT) | mem_req;
	assign mem.data  = data_arr[mem.addr.fld.index];

	// the access that completes in FILL started as a miss,
	// so only lookups from idle count as hits
	assign mem.cache_hit = mem.done & (state_q == ST_IDLE);

	assign fill_now = (state_q == ST_WAIT) & mem_valid;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE,
			ST_FILL: begin
				state_d = mem_req ? ST_WAIT : ST_IDLE;
			end
			ST_WAIT: begin
				if (mem_valid) begin
					state_d = ST_FILL;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// the fill goes to the address that missed, not the one on the bus
	always_ff @(posedge clk) begin
		if (mem_req) begin
			miss_addr_q <= mem.addr;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_now) begin
			tag_arr[miss_addr_q.fld.index]  <= miss_addr_q.fld.tag;
			data_arr[miss_addr_q.fld.index] <= mem_rdata;
		end
	end

	// valid bits
	// a program load to the same index wins over a fill in that cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			if (fill_now) begin
				valid_q[miss_addr_q.fld.index] <= 1'b1;
			end
			if (load_en) begin
				valid_q[load_addr.fld.index] <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/imem_backing.sv ====
`include "fetch_cfg.svh"

module imem_backing (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        load_en,
	input  logic [15:0] load_addr,
	input  logic [15:0] load_data,
	input  logic        mem_req,
	input  logic [15:0] mem_addr,
	output logic [15:0] mem_rdata,
	output logic        mem_valid
);

	localparam int DEPTH    = 1 << `IMEM_ADDR_BITS;
	localparam int CNT_BITS = $clog2(`IMEM_LATENCY + 1);

	logic [15:0]                mem_arr [DEPTH];
	logic [`IMEM_ADDR_BITS-1:0] load_word;
	logic [`IMEM_ADDR_BITS-1:0] req_word;
	logic [`IMEM_ADDR_BITS-1:0] rd_word_q;
	logic                       busy_q;
	logic [CNT_BITS-1:0]        cnt_q;
	logic                       accept;

	// byte addresses in, word index out; bit 0 is dropped
	assign load_word = load_addr[`IMEM_ADDR_BITS:1];
	assign req_word  = mem_addr[`IMEM_ADDR_BITS:1];

	// only one read in flight, later requests are ignored until it returns
	assign accept = mem_req & ~busy_q;

	// program load port
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem_arr[load_word] <= load_data;
		end
	end

	// latch the word address of the accepted read
	always_ff @(posedge clk) begin
		if (accept) begin
			rd_word_q <= req_word;
		end
	end

	// latency counter
	// counts down to zero, valid is raised in the zero cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (accept) begin
			busy_q <= 1'b1;
			cnt_q  <= CNT_BITS'(`IMEM_LATENCY - 1);
		end else if (busy_q) begin
			if (cnt_q == '0) begin
				busy_q <= 1'b0;
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	assign mem_valid = busy_q && (cnt_q == '0);

	// word is read in the valid cycle so a load during the wait is seen
	assign mem_rdata = mem_arr[rd_word_q];

endmodule

// ==== logic/imem_if.sv ====
interface imem_if;
	import fetch_pkg::*;

	// request side, driven by the fetch stage
	logic        rd;
	fetch_addr_u addr;

	// response side, driven by the cache
	inst_t       data;
	logic        done;
	logic        stall;
	logic        cache_hit;
	logic        err;

	modport fetch (
		output rd,
		output addr,
		input  data,
		input  done,
		input  stall,
		input  cache_hit,
		input  err
	);

	modport cache (
		input  rd,
		input  addr,
		output data,
		output done,
		output stall,
		output cache_hit,
		output err
	);

endinterface

// ==== logic/fetch_pkg.sv ====
`include "fetch_cfg.svh"

package fetch_pkg;

	// tag takes what is left of 16 bits after index and byte offset
	localparam int unsigned IC_TAG_BITS = 15 - `IC_INDEX_BITS;

	// cache view of a fetch address
	typedef struct packed {
		logic [IC_TAG_BITS-1:0]    tag;
		logic [`IC_INDEX_BITS-1:0] index;
		logic                      offset;
	} fetch_fields_t;

	// flat byte address for the PC and backing memory,
	// split fields for the cache lookup
	typedef union packed {
		logic [15:0]   flat;
		fetch_fields_t fld;
	} fetch_addr_u;

	typedef logic [15:0] inst_t;

	// bubble inserted by the fetch stage, opcode NOP
	localparam inst_t NOP_INST = 16'h0800;

endpackage

// ==== logic/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// index bits of the direct-mapped instruction cache, one word per line
`define IC_INDEX_BITS 4

// word address width of the backing memory
// address bits above this alias onto the same words
`define IMEM_ADDR_BITS 10

// cycles from a miss request to valid read data
`define IMEM_LATENCY 4

`endif
